// File: source/pbch_pkg.sv
package pbch_pkg;

    // candidate count and sequence lengths from the PBCH DMRS definition
    localparam int NUM_IBAR = 8;
    localparam int LFSR_LEN = 31;
    localparam int GOLD_NC  = 1600;
    localparam int DMRS_LEN = 144;
    localparam int IQ_W     = 16;

    typedef logic [9:0]                   cell_id_t;
    typedef logic [2:0]                   ibar_t;
    typedef logic signed [IQ_W-1:0]       iq_t;
    typedef logic [1:0]                   qpsk_t;
    typedef logic [2*NUM_IBAR-1:0]        dmrs_word_t;
    typedef logic [7:0]                   pilot_idx_t;
    typedef logic signed [7:0]            corr_t;
    typedef logic [6:0]                   peak_t;

    typedef struct packed {
        iq_t re;
        iq_t im;
    } iq_sample_t;

    // candidate i sits at index i in both arrays
    typedef struct packed {
        corr_t [NUM_IBAR-1:0] plain;
        corr_t [NUM_IBAR-1:0] rot;
    } corr_set_t;

    typedef enum logic [1:0] {IDLE, LOAD, RUN, DONE} gen_state_e;

    typedef enum logic {WAIT, SYMBOL} corr_state_e;

endpackage

// File: source/gold_sequence.sv
`timescale 1ns/100ps

module gold_sequence
    import pbch_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic                              load_i,
    input  logic [NUM_IBAR-1:0][LFSR_LEN-1:0] c_init_i,
    output logic [NUM_IBAR-1:0]               bits_o,
    output logic                              bits_valid_o
);

    localparam int SKIP_W = $clog2(GOLD_NC + 1);

    // bit k of each register holds x(n + k), so bit 0 is the current output
    logic [LFSR_LEN-1:0]               x1_q;
    logic [NUM_IBAR-1:0][LFSR_LEN-1:0] x2_q;
    logic [SKIP_W-1:0]                 skip_cnt_q;
    logic                              active_q;

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            x1_q <= LFSR_LEN'(1);
            x2_q <= c_init_i;
        end else begin
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[LFSR_LEN-1:1]};
            for (int i = 0; i < NUM_IBAR; i++) begin
                x2_q[i] <= {^x2_q[i][3:0], x2_q[i][LFSR_LEN-1:1]};
            end
        end
    end

    // counts the steps since the last load until the discarded prefix is gone
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active_q   <= 1'b0;
            skip_cnt_q <= '0;
        end else if (load_i) begin
            active_q   <= 1'b1;
            skip_cnt_q <= '0;
        end else if (active_q && skip_cnt_q != SKIP_W'(GOLD_NC)) begin
            skip_cnt_q <= skip_cnt_q + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            bits_o[i] = x1_q[0] ^ x2_q[i][0];
        end
    end

    // a pending load makes the current bits stale
    assign bits_valid_o = active_q && !load_i && (skip_cnt_q == SKIP_W'(GOLD_NC));

endmodule

// File: source/dmrs_generator.sv
`timescale 1ns/100ps

module dmrs_generator
    import pbch_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  cell_id_t                          n_id_i,
    input  logic                              n_id_valid_i,
    input  pilot_idx_t                        pilot_idx_i,
    output dmrs_word_t                        pilot_o,
    output logic [1:0]                        pilot_offset_o,
    output logic                              ready_o,
    output logic                              load_o,
    output logic [NUM_IBAR-1:0][LFSR_LEN-1:0] c_init_o,
    input  logic [NUM_IBAR-1:0]               bits_i,
    input  logic                              bits_valid_i
);

    localparam int WR_W = $clog2(2 * DMRS_LEN);

    gen_state_e          state_q;
    logic [WR_W-1:0]     wr_cnt_q;
    logic [NUM_IBAR-1:0] even_q;
    dmrs_word_t          wr_word;
    dmrs_word_t          table_q [DMRS_LEN];

    // c_init = 2^11 (ibar+1)(N_id/4+1) + 2^6 (ibar+1) + N_id mod 4
    function automatic logic [LFSR_LEN-1:0] calc_c_init(cell_id_t n_id, int ibar);
        int c;
        c = 2048 * (ibar + 1) * (int'(n_id[9:2]) + 1) + 64 * (ibar + 1) + int'(n_id[1:0]);
        return LFSR_LEN'(c);
    endfunction

    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            pilot_offset_o <= n_id_i[1:0];
            for (int i = 0; i < NUM_IBAR; i++) begin
                c_init_o[i] <= calc_c_init(n_id_i, i);
            end
        end
    end

    // a new cell ID restarts the table build from any state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q  <= IDLE;
            load_o   <= 1'b0;
            wr_cnt_q <= '0;
        end else begin
            load_o <= 1'b0;
            if (n_id_valid_i) begin
                state_q <= LOAD;
            end else begin
                case (state_q)
                    LOAD: begin
                        load_o   <= 1'b1;
                        wr_cnt_q <= '0;
                        state_q  <= RUN;
                    end
                    RUN: begin
                        if (bits_valid_i) begin
                            wr_cnt_q <= wr_cnt_q + 1'b1;
                            if (wr_cnt_q == WR_W'(2 * DMRS_LEN - 1)) begin
                                state_q <= DONE;
                            end
                        end
                    end
                    default: begin
                        state_q <= state_q;
                    end
                endcase
            end
        end
    end

    // even Gold bits wait one cycle so a whole pilot word is written at once
    always_comb begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            wr_word[2*i+1] = even_q[i];
            wr_word[2*i]   = bits_i[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RUN && bits_valid_i) begin
            if (!wr_cnt_q[0]) begin
                even_q <= bits_i;
            end else begin
                table_q[wr_cnt_q[WR_W-1:1]] <= wr_word;
            end
        end
    end

    assign pilot_o = table_q[pilot_idx_i];
    assign ready_o = (state_q == DONE);

endmodule

// File: source/dmrs_correlator.sv
`timescale 1ns/100ps

module dmrs_correlator
    import pbch_pkg::*;
#(
    parameter int SYM_LEN = 240
)
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    input  logic       sample_valid_i,
    input  logic       sym_start_i,
    input  logic       dmrs_ready_i,
    input  logic [1:0] pilot_offset_i,
    input  dmrs_word_t pilot_i,
    output pilot_idx_t pilot_idx_o,
    output corr_set_t  corr_o,
    output logic       sym_done_o
);

    localparam int SC_W = $clog2(SYM_LEN);

    corr_state_e     state_q;
    logic [SC_W-1:0] sc_cnt_q;
    pilot_idx_t      pidx_q;
    logic [1:0]      offset_q;
    corr_set_t       corr_q;
    corr_set_t       corr_d;

    logic            first;
    logic            take;
    logic            is_pilot;
    logic            last;
    logic [SC_W-1:0] sc_cur;
    logic [1:0]      offset_cur;
    qpsk_t           rx_plain;
    qpsk_t           rx_rot;

    // +1 per matching bit and -1 per mismatch
    function automatic corr_t pair_score(qpsk_t ref_pair, qpsk_t rx_pair);
        corr_t score;
        score = (ref_pair[1] == rx_pair[1]) ? corr_t'(1) : corr_t'(-1);
        score = score + ((ref_pair[0] == rx_pair[0]) ? corr_t'(1) : corr_t'(-1));
        return score;
    endfunction

    // hard decisions on the signs where the second pair undoes a rotation by -j
    assign rx_plain = {sample_i.re[IQ_W-1], sample_i.im[IQ_W-1]};
    assign rx_rot   = {~sample_i.im[IQ_W-1], sample_i.re[IQ_W-1]};

    // the first sample is processed in the cycle its start is accepted
    assign first = (state_q == WAIT) && sym_start_i && sample_valid_i && dmrs_ready_i;
    assign take  = first || (state_q == SYMBOL && sample_valid_i);

    assign sc_cur      = first ? '0 : sc_cnt_q;
    assign offset_cur  = first ? pilot_offset_i : offset_q;
    assign pilot_idx_o = first ? '0 : pidx_q;
    assign is_pilot    = take && (sc_cur[1:0] == offset_cur);
    assign last        = take && (sc_cur == SC_W'(SYM_LEN - 1));

    always_comb begin
        corr_d = first ? '0 : corr_q;
        if (is_pilot) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                corr_d.plain[i] = corr_d.plain[i] + pair_score(pilot_i[2*i +: 2], rx_plain);
                corr_d.rot[i]   = corr_d.rot[i] + pair_score(pilot_i[2*i +: 2], rx_rot);
            end
        end
    end

    // sums stay put after the symbol so the selector sees them stable
    always_ff @(posedge clk_i) begin
        if (take) begin
            corr_q <= corr_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= WAIT;
            sc_cnt_q   <= '0;
            pidx_q     <= '0;
            offset_q   <= '0;
            sym_done_o <= 1'b0;
        end else begin
            sym_done_o <= last;
            if (first) begin
                offset_q <= pilot_offset_i;
                state_q  <= SYMBOL;
            end
            if (take) begin
                sc_cnt_q <= sc_cur + 1'b1;
                pidx_q   <= is_pilot ? pilot_idx_o + 1'b1 : pilot_idx_o;
            end
            if (last) begin
                state_q <= WAIT;
            end
        end
    end

    assign corr_o = corr_q;

endmodule

// File: source/ibar_selector.sv
`timescale 1ns/100ps

module ibar_selector
    import pbch_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_ni,
    input  corr_set_t corr_i,
    input  logic      sym_done_i,
    output ibar_t     ibar_o,
    output peak_t     peak_o,
    output logic      ibar_valid_o
);

    peak_t cand_mag [NUM_IBAR];
    peak_t best_peak;
    ibar_t best_ibar;

    function automatic peak_t magnitude(corr_t value);
        return peak_t'(value[7] ? -value : value);
    endfunction

    // per candidate keep whichever of the two phase hypotheses fits better
    always_comb begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            if (magnitude(corr_i.rot[i]) > magnitude(corr_i.plain[i])) begin
                cand_mag[i] = magnitude(corr_i.rot[i]);
            end else begin
                cand_mag[i] = magnitude(corr_i.plain[i]);
            end
        end
    end

    // a strict compare lets the lower ibar win a tie
    always_comb begin
        best_ibar = '0;
        best_peak = cand_mag[0];
        for (int i = 1; i < NUM_IBAR; i++) begin
            if (cand_mag[i] > best_peak) begin
                best_ibar = ibar_t'(i);
                best_peak = cand_mag[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_o       <= '0;
            peak_o       <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= sym_done_i;
            if (sym_done_i) begin
                ibar_o <= best_ibar;
                peak_o <= best_peak;
            end
        end
    end

endmodule

// File: source/pbch_dmrs_detector.sv
`timescale 1ns/100ps

module pbch_dmrs_detector
    import pbch_pkg::*;
#(
    parameter int SYM_LEN = 240
)
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  cell_id_t   n_id_i,
    input  logic       n_id_valid_i,
    input  iq_sample_t sample_i,
    input  logic       sample_valid_i,
    input  logic       sym_start_i,
    output logic       dmrs_ready_o,
    output ibar_t      ibar_o,
    output peak_t      peak_o,
    output logic       ibar_valid_o
);

    logic                              load;
    logic [NUM_IBAR-1:0][LFSR_LEN-1:0] c_init;
    logic [NUM_IBAR-1:0]               gold_bits;
    logic                              gold_valid;
    pilot_idx_t                        pilot_idx;
    dmrs_word_t                        pilot;
    logic [1:0]                        pilot_offset;
    corr_set_t                         corr;
    logic                              sym_done;

    gold_sequence u_gold (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .load_i       (load),
        .c_init_i     (c_init),
        .bits_o       (gold_bits),
        .bits_valid_o (gold_valid)
    );

    dmrs_generator u_generator (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .pilot_idx_i    (pilot_idx),
        .pilot_o        (pilot),
        .pilot_offset_o (pilot_offset),
        .ready_o        (dmrs_ready_o),
        .load_o         (load),
        .c_init_o       (c_init),
        .bits_i         (gold_bits),
        .bits_valid_i   (gold_valid)
    );

    dmrs_correlator #(
        .SYM_LEN (SYM_LEN)
    ) u_correlator (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sym_start_i    (sym_start_i),
        .dmrs_ready_i   (dmrs_ready_o),
        .pilot_offset_i (pilot_offset),
        .pilot_i        (pilot),
        .pilot_idx_o    (pilot_idx),
        .corr_o         (corr),
        .sym_done_o     (sym_done)
    );

    ibar_selector u_selector (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .corr_i       (corr),
        .sym_done_i   (sym_done),
        .ibar_o       (ibar_o),
        .peak_o       (peak_o),
        .ibar_valid_o (ibar_valid_o)
    );

endmodule

// File: verif/pbch_dmrs_assert.sv
`timescale 1ns/100ps

module pbch_dmrs_assert (
    input logic clk_i,
    input logic reset_ni,
    input logic n_id_valid_i,
    input logic dmrs_ready_i,
    input logic ibar_valid_i
);

    // a result is reported once per symbol
    a_single_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |=> !ibar_valid_i)
        else $error("ibar_valid_o stayed high for two cycles");

    a_valid_needs_ready: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |-> dmrs_ready_i)
        else $error("ibar_valid_o high while dmrs_ready_o is low");

    // the old pilot table is invalid as soon as a new cell ID arrives
    a_ready_drops: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !dmrs_ready_i)
        else $error("dmrs_ready_o still high after n_id_valid_i");

endmodule

bind pbch_dmrs_detector pbch_dmrs_assert u_assert (
    .clk_i        (clk_i),
    .reset_ni     (reset_ni),
    .n_id_valid_i (n_id_valid_i),
    .dmrs_ready_i (dmrs_ready_o),
    .ibar_valid_i (ibar_valid_o)
);

// File: verif/dmrs_model.svh
`ifndef DMRS_MODEL_SVH
`define DMRS_MODEL_SVH

// sequence terms needed to reach the last stored Gold bit
localparam int GOLD_SPAN = GOLD_NC + 2 * DMRS_LEN + LFSR_LEN;

// c_init of the PBCH DMRS for one candidate ibar_SSB
function automatic logic [LFSR_LEN-1:0] c_init_of(input int n_id, input int ibar);
    int value;
    value = (1 << 11) * (ibar + 1) * (n_id / 4 + 1) + (1 << 6) * (ibar + 1) + n_id % 4;
    return LFSR_LEN'(value);
endfunction

// bit n of the result is c(n), the Gold bit after the discarded prefix
function automatic logic [2*DMRS_LEN-1:0] gold_bits(input logic [LFSR_LEN-1:0] c_init);
    logic [GOLD_SPAN-1:0]    x1;
    logic [GOLD_SPAN-1:0]    x2;
    logic [2*DMRS_LEN-1:0]   c;
    x1 = '0;
    x2 = '0;
    x1[0] = 1'b1;
    x2[LFSR_LEN-1:0] = c_init;
    for (int n = 0; n + LFSR_LEN < GOLD_SPAN; n++) begin
        x1[n+LFSR_LEN] = x1[n+3] ^ x1[n];
        x2[n+LFSR_LEN] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
    end
    for (int n = 0; n < 2 * DMRS_LEN; n++) begin
        c[n] = x1[n+GOLD_NC] ^ x2[n+GOLD_NC];
    end
    return c;
endfunction

// pilot m takes the even Gold bit as bit 1 and the odd one as bit 0
function automatic qpsk_t pilot_pair(input logic [2*DMRS_LEN-1:0] gold, input int m);
    qpsk_t pair;
    pair[1] = gold[2*m];
    pair[0] = gold[2*m+1];
    return pair;
endfunction

`endif

// File: verif/tb_pbch_dmrs_detector.sv
`timescale 1ns/100ps

module tb_pbch_dmrs_detector
    import pbch_pkg::*;
();

    localparam int  SYM_LEN     = 240;
    localparam int  NUM_PILOTS  = SYM_LEN / 4;
    localparam int  NUM_TESTS   = 12;
    localparam int  FIELDS      = 8;
    localparam int  CYCLE_LIMIT = NUM_TESTS * (GOLD_NC + 2 * DMRS_LEN + 3 * SYM_LEN + 200);
    localparam iq_t AMP         = 16'sd4096;

    `include "dmrs_model.svh"

    logic       clk_i;
    logic       reset_ni;
    cell_id_t   n_id_i;
    logic       n_id_valid_i;
    iq_sample_t sample_i;
    logic       sample_valid_i;
    logic       sym_start_i;
    logic       dmrs_ready_o;
    ibar_t      ibar_o;
    peak_t      peak_o;
    logic       ibar_valid_o;

    logic [15:0] test_mem [NUM_TESTS * FIELDS];
    iq_sample_t  sym_buf [SYM_LEN];
    int          seed = 32'hd28a7224;
    int          cycles = 0;
    int          errors = 0;
    int          failed_tests = 0;
    bit          test_failed;

    pbch_dmrs_detector #(
        .SYM_LEN (SYM_LEN)
    ) DUT (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sym_start_i    (sym_start_i),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_o         (ibar_o),
        .peak_o         (peak_o),
        .ibar_valid_o   (ibar_valid_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
            test_failed = 1'b1;
        end
    endtask

    // one strobe with the new cell ID drops ready one cycle later
    task automatic load_cell(input int n_id);
        @(posedge clk_i);
        n_id_i       <= cell_id_t'(n_id);
        n_id_valid_i <= 1'b1;
        @(posedge clk_i);
        n_id_valid_i <= 1'b0;
        @(negedge clk_i);
        check_value("dmrs_ready_o", dmrs_ready_o, 0);
    endtask

    task automatic wait_for_ready();
        while (!dmrs_ready_o) begin
            @(negedge clk_i);
            if (ibar_valid_o) begin
                $display("ibar_valid_o pulsed for a symbol started before dmrs_ready_o rose");
                errors++;
                test_failed = 1'b1;
            end
        end
    endtask

    task automatic build_symbol(input int n_id, input int ibar, input bit rot, input int flips);
        logic [2*DMRS_LEN-1:0]   gold;
        logic [2*NUM_PILOTS-1:0] flip_mask;
        qpsk_t                   pair;
        iq_sample_t              s;
        int                      pos;
        int                      m;
        gold      = gold_bits(c_init_of(n_id, ibar));
        flip_mask = '0;
        for (int f = 0; f < flips; f++) begin
            do begin
                pos = int'($unsigned($random(seed)) % (2 * NUM_PILOTS));
            end while (flip_mask[pos]);
            flip_mask[pos] = 1'b1;
        end
        m = 0;
        for (int k = 0; k < SYM_LEN; k++) begin
            if (k % 4 == n_id % 4) begin
                pair = pilot_pair(gold, m) ^ flip_mask[2*m +: 2];
                s.re = pair[1] ? -AMP : AMP;
                s.im = pair[0] ? -AMP : AMP;
                m++;
            end else begin
                s.re = iq_t'($random(seed));
                s.im = iq_t'($random(seed));
            end
            // times -j turns re + j im into im - j re
            if (rot) begin
                sym_buf[k].re = s.im;
                sym_buf[k].im = -s.re;
            end else begin
                sym_buf[k] = s;
            end
        end
    endtask

    task automatic send_symbol(input bit use_gaps);
        int k;
        k = 0;
        while (k < SYM_LEN) begin
            @(posedge clk_i);
            if (use_gaps && (($random(seed) & 3) == 0)) begin
                sample_i       <= '0;
                sample_valid_i <= 1'b0;
                sym_start_i    <= 1'b0;
            end else begin
                sample_i       <= sym_buf[k];
                sample_valid_i <= 1'b1;
                sym_start_i    <= (k == 0);
                k++;
            end
        end
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
        sym_start_i    <= 1'b0;
    endtask

    initial begin
        int base;
        bit new_cell;
        int n_id;
        int ibar;
        bit rot;
        int flips;
        bit early;
        bit use_gaps;
        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        n_id_i         = '0;
        n_id_valid_i   = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        sym_start_i    = 1'b0;
        $readmemh("verif/pbch_tests.txt", test_mem);
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        check_value("dmrs_ready_o", dmrs_ready_o, 0);
        check_value("ibar_valid_o", ibar_valid_o, 0);
        check_value("ibar_o", ibar_o, 0);
        check_value("peak_o", peak_o, 0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            base        = t * FIELDS;
            new_cell    = test_mem[base][0];
            n_id        = int'(test_mem[base+1]);
            ibar        = int'(test_mem[base+2]);
            rot         = test_mem[base+3][0];
            flips       = int'(test_mem[base+4]);
            early       = test_mem[base+5][0];
            use_gaps    = (t % 2 == 1);
            test_failed = 1'b0;
            if (new_cell) begin
                load_cell(n_id);
            end
            // a start while the table is rebuilt has to be ignored
            if (early) begin
                send_symbol(1'b0);
            end
            wait_for_ready();
            build_symbol(n_id, ibar, rot, flips);
            send_symbol(use_gaps);
            do @(negedge clk_i); while (!ibar_valid_o);
            check_value("ibar_o", ibar_o, test_mem[base+6]);
            check_value("peak_o", peak_o, test_mem[base+7]);
            if (test_failed) begin
                failed_tests++;
            end
            $display("test %0d: n_id %0d ibar %0d rot %0b flips %0d gaps %0b early %0b %s",
                     t, n_id, ibar, rot, flips, use_gaps, early,
                     test_failed ? "failed" : "ok");
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verif/pbch_tests.txt
// new_cell n_id ibar rotate flips early exp_ibar exp_peak, all in hex
// exp_peak is 2*60 - 2*flips for a 240 sample symbol
1 000 0 0 00 0 0 78
0 000 5 0 00 0 5 78
1 1f5 3 0 00 1 3 78
0 1f5 3 1 00 0 3 78
1 3ef 7 0 05 0 7 6e
0 3ef 1 1 08 0 1 68
1 00a 6 0 00 1 6 78
0 00a 6 0 00 0 6 78
1 2c3 2 0 0c 0 2 60
0 2c3 4 1 03 0 4 72
1 100 1 0 00 1 1 78
0 100 7 1 00 0 7 78

// File: sources.f
+incdir+verif
source/pbch_pkg.sv
source/gold_sequence.sv
source/dmrs_generator.sv
source/dmrs_correlator.sv
source/ibar_selector.sv
source/pbch_dmrs_detector.sv
verif/pbch_dmrs_assert.sv
verif/tb_pbch_dmrs_detector.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_pbch_dmrs_detector \
    -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
